// ==== compile.f ====
+incdir+.
cache_pkg.sv
way_probe_if.sv
plru_if.sv
lookup_ctrl.sv
tag_way.sv
plru_resolve.sv
tag_lookup_top.sv
tb_clock_gen.sv
tag_lookup_assertions.sv
tag_lookup_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tag_lookup_tb
FILELIST   := compile.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_FLAGS  := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tag_lookup_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tag_lookup_tb;

    localparam int SEED         = 9;
    localparam int WAIT_LIMIT   = 50;
    localparam int RANDOM_COUNT = 300;

    logic                  clk;
    logic                  rst;
    logic                  req;
    cache_pkg::set_index_t index;
    cache_pkg::tag_t       tag;
    logic                  ack;
    logic                  hit;
    cache_pkg::way_t       way;

    // Reference state per set.
    logic                  model_valid [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::tag_t       model_tag   [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::plru_bits_t model_plru  [`CACHE_SETS];

    tb_clock_gen clock0 (
        .clk (clk),
        .rst (rst)
    );

    tag_lookup_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .index (index),
        .tag   (tag),
        .ack   (ack),
        .hit   (hit),
        .way   (way)
    );

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_expired(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    function automatic cache_pkg::tag_t make_tag(input int set_no, input int k);
        return cache_pkg::tag_t'(16 * set_no + k);
    endfunction

    // The lowest empty way goes first and the tree decides once the set is full.
    function automatic cache_pkg::way_t pick_victim(input cache_pkg::set_index_t s);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!model_valid[s][w]) begin
                return cache_pkg::way_t'(w);
            end
        end
        if (model_plru[s][0]) begin
            return model_plru[s][2] ? 2'd3 : 2'd2;
        end
        return model_plru[s][1] ? 2'd1 : 2'd0;
    endfunction

    function automatic void touch_way(input cache_pkg::set_index_t s,
                                      input cache_pkg::way_t w);
        if (w < 2) begin
            model_plru[s][0] = 1'b1;
            model_plru[s][1] = (w == 0);
        end else begin
            model_plru[s][0] = 1'b0;
            model_plru[s][2] = (w == 2);
        end
    endfunction

    function automatic void predict(input cache_pkg::set_index_t s, input cache_pkg::tag_t t,
                                    output logic exp_hit, output cache_pkg::way_t exp_way);
        exp_hit = 1'b0;
        exp_way = pick_victim(s);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                exp_hit = 1'b1;
                exp_way = cache_pkg::way_t'(w);
            end
        end
        if (!exp_hit) begin
            model_valid[s][exp_way] = 1'b1;
            model_tag[s][exp_way]   = t;
        end
        touch_way(s, exp_way);
    endfunction

    // One full four-phase handshake checked against the model.
    task automatic do_lookup(input cache_pkg::set_index_t s, input cache_pkg::tag_t t,
                             input int hold, output logic got_hit,
                             output cache_pkg::way_t got_way);
        logic            exp_hit;
        cache_pkg::way_t exp_way;
        int              waited;
        predict(s, t, exp_hit, exp_way);
        @(posedge clk);
        req   <= 1'b1;
        index <= s;
        tag   <= t;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                wait_expired("ack to rise");
            end
        end while (!ack);
        got_hit = hit;
        got_way = way;
        check_value("hit", 32'(hit), 32'(exp_hit));
        check_value("way", 32'(way), 32'(exp_way));
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("ack", 32'(ack), 32'd1);
            check_value("hit", 32'(hit), 32'(exp_hit));
            check_value("way", 32'(way), 32'(exp_way));
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                wait_expired("ack to fall");
            end
        end while (ack);
    endtask

    task automatic expect_lookup(input int set_no, input int k, input logic want_hit,
                                 input int want_way);
        logic            got_hit;
        cache_pkg::way_t got_way;
        int              hold;
        hold = int'($urandom_range(0, 5));
        do_lookup(cache_pkg::set_index_t'(set_no), make_tag(set_no, k), hold, got_hit, got_way);
        check_value("hit", 32'(got_hit), 32'(want_hit));
        check_value("way", 32'(got_way), 32'(want_way));
    endtask

    always @(negedge clk) begin
        if (dut0.u_assertions.any_failed) begin
            $display("A protocol assertion on the DUT ports failed");
            abort_run();
        end
    end

    initial begin
        logic            got_hit;
        cache_pkg::way_t got_way;
        int              waited;
        int              set_no;
        int              k;
        req   = 1'b0;
        index = '0;
        tag   = '0;
        void'($urandom(SEED));
        for (int s = 0; s < `CACHE_SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                wait_expired("reset release");
            end
        end while (rst);
        check_value("ack", 32'(ack), 32'd0);
        check_value("hit", 32'(hit), 32'd0);
        check_value("way", 32'(way), 32'd0);

        // Cold sets fill ways in order and then the same tags hit.
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 4; w++) begin
                expect_lookup(s, w, 1'b0, w);
            end
        end
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 4; w++) begin
                expect_lookup(s, w, 1'b1, w);
            end
        end

        // Set 5 touched in order 0 to 3 evicts way 0 next.
        for (int w = 0; w < 4; w++) begin
            expect_lookup(5, w, 1'b0, w);
        end
        for (int w = 0; w < 4; w++) begin
            expect_lookup(5, w, 1'b1, w);
        end
        expect_lookup(5, 4, 1'b0, 0);
        // Touching ways 3, 0 and 1 leaves way 2 as the victim.
        expect_lookup(5, 3, 1'b1, 3);
        expect_lookup(5, 4, 1'b1, 0);
        expect_lookup(5, 1, 1'b1, 1);
        expect_lookup(5, 5, 1'b0, 2);

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            set_no = int'($urandom_range(0, 3));
            k      = int'($urandom_range(0, 5));
            do_lookup(cache_pkg::set_index_t'(set_no), make_tag(set_no, k),
                      int'($urandom_range(0, 5)), got_hit, got_way);
        end

        if (dut0.u_assertions.any_failed) begin
            $display("A protocol assertion on the DUT ports failed");
            abort_run();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tag_lookup_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_lookup_assertions (
    input logic            clk,
    input logic            rst,
    input logic            req,
    input logic            ack,
    input logic            hit,
    input cache_pkg::way_t way
);

    logic rise_err   = 1'b0;
    logic delay_err  = 1'b0;
    logic hold_err   = 1'b0;
    logic stable_err = 1'b0;
    logic reset_err  = 1'b0;
    logic any_failed;

    assign any_failed = rise_err | delay_err | hold_err | stable_err | reset_err;

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req)
        else begin
            rise_err = 1'b1;
            $error("ack rose while req was low");
        end

    // A fresh request in idle is answered two edges later.
    ack_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(req) && !ack |-> ##1 !ack ##1 ack)
        else begin
            delay_err = 1'b1;
            $error("ack did not rise two cycles after the request");
        end

    ack_held: assert property (@(posedge clk) disable iff (rst)
        ack && req |=> ack)
        else begin
            hold_err = 1'b1;
            $error("ack dropped while req was still high");
        end

    response_stable: assert property (@(posedge clk) disable iff (rst)
        ack && $past(ack) |-> $stable(hit) && $stable(way))
        else begin
            stable_err = 1'b1;
            $error("hit or way changed while ack was high");
        end

    ack_low_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !ack)
        else begin
            reset_err = 1'b1;
            $error("ack was high during reset");
        end

endmodule

bind tag_lookup_top tag_lookup_assertions u_assertions (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack),
    .hit (hit),
    .way (way)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset drops on a rising edge, like any other stimulus.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tag_lookup_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tag_lookup_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  cache_pkg::set_index_t index,
    input  cache_pkg::tag_t       tag,
    output logic                  ack,
    output logic                  hit,
    output cache_pkg::way_t       way
);

    way_probe_if probe_bus ();
    plru_if      lru_bus ();

    lookup_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .index (index),
        .tag   (tag),
        .ack   (ack),
        .hit   (hit),
        .way   (way),
        .probe (probe_bus.ctrl),
        .lru   (lru_bus.ctrl)
    );

    // One bank per way, each owns its bit of the hit and valid masks.
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        tag_way #(
            .WAY_ID (w)
        ) u_way (
            .clk   (clk),
            .rst   (rst),
            .probe (probe_bus.bank)
        );
    end

    plru_resolve u_plru (
        .clk   (clk),
        .rst   (rst),
        .probe (probe_bus.drain),
        .lru   (lru_bus.resolver)
    );

endmodule

`default_nettype wire

// ==== plru_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module plru_resolve (
    input logic        clk,
    input logic        rst,
    way_probe_if.drain probe,
    plru_if.resolver   lru
);

    cache_pkg::plru_bits_t plru_state [`CACHE_SETS];
    cache_pkg::plru_bits_t cur_bits;
    cache_pkg::plru_bits_t next_bits;

    // Walk the tree from the root down to the way it points at.
    function automatic cache_pkg::way_t tree_victim(input cache_pkg::plru_bits_t bits);
        cache_pkg::way_t w;
        if (bits[0]) begin
            w = {1'b1, bits[2]};
        end else begin
            w = {1'b0, bits[1]};
        end
        return w;
    endfunction

    // Point the root and the touched pair away from the accessed way.
    function automatic cache_pkg::plru_bits_t tree_touch(
        input cache_pkg::plru_bits_t bits,
        input cache_pkg::way_t       w
    );
        cache_pkg::plru_bits_t nb;
        nb    = bits;
        nb[0] = ~w[1];
        if (w[1]) begin
            nb[2] = ~w[0];
        end else begin
            nb[1] = ~w[0];
        end
        return nb;
    endfunction

    assign cur_bits  = plru_state[lru.index];
    assign next_bits = tree_touch(cur_bits, lru.update_way);

    assign lru.hit_any = |probe.hit_mask;

    // At most one bank hits, lowest index taken if that ever breaks.
    always_comb begin
        lru.hit_way = '0;
        for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
            if (probe.hit_mask[i]) begin
                lru.hit_way = cache_pkg::way_t'(i);
            end
        end
    end

    // An empty way is always preferred over evicting a live one.
    always_comb begin
        lru.victim_way = tree_victim(cur_bits);
        for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
            if (!probe.valid_mask[i]) begin
                lru.victim_way = cache_pkg::way_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            plru_state <= '{default: '0};
        end else if (lru.update_en) begin
            plru_state[lru.index] <= next_bits;
        end
    end

endmodule

`default_nettype wire

// ==== tag_way.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tag_way #(
    parameter int WAY_ID = 0
) (
    input logic       clk,
    input logic       rst,
    way_probe_if.bank probe
);

    logic [`CACHE_SETS-1:0] valid;
    cache_pkg::tag_t        tags [`CACHE_SETS];

    logic fill;

    assign fill = probe.fill_mask[WAY_ID];

    // Compare against the probed set.
    assign probe.valid_mask[WAY_ID] = valid[probe.index];
    assign probe.hit_mask[WAY_ID]   = valid[probe.index] &&
                                      (tags[probe.index] == probe.tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[probe.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[probe.index] <= probe.tag;
        end
    end

endmodule

`default_nettype wire

// ==== lookup_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lookup_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  cache_pkg::set_index_t index,
    input  cache_pkg::tag_t       tag,
    output logic                  ack,
    output logic                  hit,
    output cache_pkg::way_t       way,
    way_probe_if.ctrl             probe,
    plru_if.ctrl                  lru
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::set_index_t  req_index;
    cache_pkg::tag_t        req_tag;
    cache_pkg::way_t        chosen_way;
    logic                   update_en;

    // Hit way wins, otherwise the resolver's victim gets the fill.
    assign chosen_way = lru.hit_any ? lru.hit_way : lru.victim_way;

    // The banks and the resolver see the captured request, not the live ports.
    assign probe.index = req_index;
    assign probe.tag   = req_tag;
    assign lru.index   = req_index;

    // The response registers hold the chosen way during the update cycle.
    assign lru.update_en  = update_en;
    assign lru.update_way = way;

    // Fill strobe shares the update pulse and only fires on a miss.
    always_comb begin
        probe.fill_mask = '0;
        if (update_en && !hit) begin
            probe.fill_mask = cache_pkg::way_mask_t'(1) << way;
        end
    end

    // Request capture.
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && req) begin
            req_index <= index;
            req_tag   <= tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= cache_pkg::IDLE;
            ack       <= 1'b0;
            hit       <= 1'b0;
            way       <= '0;
            update_en <= 1'b0;
        end else begin
            update_en <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (req) begin
                        state <= cache_pkg::PROBE;
                    end
                end
                cache_pkg::PROBE: begin
                    hit       <= lru.hit_any;
                    way       <= chosen_way;
                    update_en <= 1'b1;
                    ack       <= 1'b1;
                    state     <= cache_pkg::RESPOND;
                end
                cache_pkg::RESPOND: begin
                    // Client back-pressure, ack holds until req is seen low.
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= cache_pkg::RELEASE;
                    end
                end
                cache_pkg::RELEASE: begin
                    state <= cache_pkg::IDLE;
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== plru_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface plru_if;

    // Resolver results for the probed set.
    logic                  hit_any;
    cache_pkg::way_t       hit_way;
    cache_pkg::way_t       victim_way;
    // Tree update request from the controller.
    cache_pkg::set_index_t index;
    logic                  update_en;
    cache_pkg::way_t       update_way;

    modport ctrl (
        input  hit_any,
        input  hit_way,
        input  victim_way,
        output index,
        output update_en,
        output update_way
    );

    modport resolver (
        output hit_any,
        output hit_way,
        output victim_way,
        input  index,
        input  update_en,
        input  update_way
    );

endinterface

`default_nettype wire

// ==== way_probe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface way_probe_if;

    cache_pkg::set_index_t index;
    cache_pkg::tag_t       tag;
    // One-hot write strobe, all zero when nothing is filled.
    cache_pkg::way_mask_t  fill_mask;
    // One bit per bank, each bank drives its own bit.
    cache_pkg::way_mask_t  hit_mask;
    cache_pkg::way_mask_t  valid_mask;

    modport ctrl (
        output index,
        output tag,
        output fill_mask
    );

    modport bank (
        input  index,
        input  tag,
        input  fill_mask,
        output hit_mask,
        output valid_mask
    );

    modport drain (
        input hit_mask,
        input valid_mask
    );

endinterface

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef logic [$clog2(`CACHE_SETS)-1:0] set_index_t;
    typedef logic [`CACHE_TAG_BITS-1:0]     tag_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_WAYS-1:0]         way_mask_t;

    // Bit 0 is the root, bit 1 the left pair, bit 2 the right pair.
    typedef logic [`CACHE_WAYS-2:0]         plru_bits_t;

    typedef enum logic [1:0] {
        IDLE,
        PROBE,
        RESPOND,
        RELEASE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Associativity is fixed by the tree PLRU, which only covers four ways.
`define CACHE_WAYS 4

// Sets per way bank.
`define CACHE_SETS 16

// Tag width in bits.
`define CACHE_TAG_BITS 8

`endif
